// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator, pass only if the log holds the pass line
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal -f sdram_burst_top.f \
  --top-module tb_sdram_burst -o sim_tb && \
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sdram_access_fsm.sv ====
// Host-side access FSM and chip bus mux
// One-deep request queue, single-word writes with auto precharge,
// full-page reads that run until end_burst, the page edge or a refresh
// Host must take every word as it comes, the only flow control is available
// CAS latency of 2 or 3 assumed by the in-flight word pipeline
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_access_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  sdram_pkg::host_req_t     req,
  input  logic                     end_burst,
  input  sdram_pkg::sdram_bus_t    init_bus,
  input  logic                     init_complete,
  input  logic                     refresh_due,
  output logic                     refresh_issued,
  output sdram_pkg::sdram_bus_t    bus,
  output logic [`SDRAM_DATA_W-1:0] dq_out,
  output logic                     dq_oe,
  input  logic [`SDRAM_DATA_W-1:0] dq_in,
  output logic [`SDRAM_DATA_W-1:0] q,
  output logic                     available,
  output logic                     ready,
  output logic                     data_available
);

  localparam int CL = `SDRAM_CAS_LATENCY;
  localparam int PAD_W = `SDRAM_ROW_W - `SDRAM_COL_W - 1;

  // Last column requested before the burst stops on its own
  localparam logic [`SDRAM_COL_W-1:0] STOP_COL = `SDRAM_COL_W'((1 << `SDRAM_COL_W) - CL);
  // Below this column a due refresh may cut the burst
  localparam logic [`SDRAM_COL_W-1:0] GUARD_COL = STOP_COL - `SDRAM_COL_W'(`SDRAM_PAGE_GUARD);
  localparam logic [`SDRAM_ROW_W-1:0] A10_ALL = `SDRAM_ROW_W'(1 << 10);

  sdram_pkg::access_state_e state;
  sdram_pkg::access_state_e wait_next;
  sdram_pkg::host_req_t     req_q;
  sdram_pkg::host_req_t     cur;
  sdram_pkg::sdram_bus_t    bus_r;

  logic                     pend;
  logic                     job;
  logic                     new_req;
  logic [3:0]               wait_cnt;
  logic [`SDRAM_COL_W-1:0]  col;
  // One bit per read word in flight between command and DQ
  logic [CL-1:0]            rd_pipe;

  assign new_req = req.wr || req.rd;
  // Queued request wins, otherwise act on the live one
  assign cur = pend ? req_q : req;

  ////////////////////
  // Host side outputs

  assign q              = dq_in;
  assign data_available = rd_pipe[CL-1];
  assign available      = init_complete && state == sdram_pkg::ST_IDLE && !pend && !ready &&
                          rd_pipe == '0;

  // Init sequencer owns the bus until it hands over
  assign bus = init_complete ? bus_r : init_bus;

  ////////////////////
  // Command FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= sdram_pkg::ST_IDLE;
      wait_next      <= sdram_pkg::ST_IDLE;
      wait_cnt       <= '0;
      pend           <= 1'b0;
      job            <= 1'b0;
      rd_pipe        <= '0;
      ready          <= 1'b0;
      refresh_issued <= 1'b0;
      dq_oe          <= 1'b0;
      bus_r.cmd      <= sdram_pkg::CMD_NOP;
      bus_r.ba       <= '0;
      bus_r.a        <= '0;
      bus_r.dqm      <= '0;
      bus_r.cke      <= 1'b0;
    end else begin
      // NOP, DQ released and pulses low unless a state says otherwise
      bus_r.cmd      <= sdram_pkg::CMD_NOP;
      bus_r.cke      <= 1'b1;
      bus_r.dqm      <= '0;
      dq_oe          <= 1'b0;
      ready          <= 1'b0;
      refresh_issued <= 1'b0;
      // Every burst cycle asks for one word, which lands CL cycles later
      rd_pipe <= {rd_pipe[CL-2:0], state == sdram_pkg::ST_BURST};

      // Capture into the queue, cleared below if the job starts at once
      if (new_req) begin
        req_q <= req;
        pend  <= 1'b1;
      end

      case (state)
        sdram_pkg::ST_IDLE: begin
          if (init_complete) begin
            if (refresh_due) begin
              // Refresh first, any request stays queued
              bus_r.cmd      <= sdram_pkg::CMD_AUTO_REFRESH;
              refresh_issued <= 1'b1;
              state          <= sdram_pkg::ST_WAIT;
              wait_cnt       <= 4'(`SDRAM_T_RFC - 2);
              wait_next      <= sdram_pkg::ST_IDLE;
            end else if (pend || new_req) begin
              // Open the row, bank from the top address bits
              bus_r.cmd <= sdram_pkg::CMD_ACTIVE;
              bus_r.ba  <= cur.addr[`SDRAM_ADDR_W-1 -: 2];
              bus_r.a   <= cur.addr[`SDRAM_COL_W +: `SDRAM_ROW_W];
              pend      <= 1'b0;
              job       <= 1'b1;
              state     <= sdram_pkg::ST_WAIT;
              wait_cnt  <= 4'(`SDRAM_T_RCD - 1);
              wait_next <= cur.wr ? sdram_pkg::ST_WRITE : sdram_pkg::ST_READ;
            end
          end
        end
        sdram_pkg::ST_WAIT: begin
          if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 4'd1;
          end else begin
            state <= wait_next;
            // Job ends once the bus is back in idle
            if (wait_next == sdram_pkg::ST_IDLE && job) begin
              ready <= 1'b1;
              job   <= 1'b0;
            end
          end
        end
        sdram_pkg::ST_WRITE: begin
          // Single word with auto precharge via A10
          bus_r.cmd <= sdram_pkg::CMD_WRITE;
          bus_r.ba  <= req_q.addr[`SDRAM_ADDR_W-1 -: 2];
          bus_r.a   <= {{PAD_W{1'b0}}, 1'b1, req_q.addr[`SDRAM_COL_W-1:0]};
          bus_r.dqm <= ~req_q.byte_en;
          dq_out    <= req_q.data;
          dq_oe     <= 1'b1;
          // Covers tWR plus tRP before the next command
          state     <= sdram_pkg::ST_WAIT;
          wait_cnt  <= 4'(`SDRAM_T_WR_RP - 2);
          wait_next <= sdram_pkg::ST_IDLE;
        end
        sdram_pkg::ST_READ: begin
          // Full-page burst, row stays open until PRECHARGE
          bus_r.cmd <= sdram_pkg::CMD_READ;
          bus_r.ba  <= req_q.addr[`SDRAM_ADDR_W-1 -: 2];
          bus_r.a   <= {{PAD_W{1'b0}}, 1'b0, req_q.addr[`SDRAM_COL_W-1:0]};
          col       <= req_q.addr[`SDRAM_COL_W-1:0];
          state     <= sdram_pkg::ST_BURST;
        end
        sdram_pkg::ST_BURST: begin
          col <= col + 1'b1;
          // Host stop, page edge, or a refresh far enough from the edge
          if (end_burst || col >= STOP_COL || (refresh_due && col < GUARD_COL)) begin
            bus_r.cmd <= sdram_pkg::CMD_PRECHARGE;
            bus_r.a   <= A10_ALL;
            state     <= sdram_pkg::ST_WAIT;
            wait_cnt  <= 4'(`SDRAM_T_RP - 2);
            wait_next <= sdram_pkg::ST_IDLE;
          end
        end
        default: begin
          state <= sdram_pkg::ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Protocol checks

  // Host honours the available handshake
  assert property (@(posedge clk) disable iff (reset) (req.wr || req.rd) |-> available)
    else $error("request while available is low");

  // Row must be open for tRCD before any column command
  assert property (@(posedge clk) disable iff (reset)
    bus.cmd == sdram_pkg::CMD_ACTIVE |=> (bus.cmd == sdram_pkg::CMD_NOP) [* `SDRAM_T_RCD])
    else $error("column command inside tRCD");

endmodule

// ==== sdram_burst_top.f ====
+incdir+.
sdram_pkg.sv
sdram_init_seq.sv
sdram_refresh_timer.sv
sdram_access_fsm.sv
sdram_burst_top.sv
sdram_chip_model.sv
tb_sdram_burst.sv

// ==== sdram_burst_top.sv ====
// SDRAM burst controller top
// DQ is split into dq_out, dq_oe and dq_in, the tristate pad sits outside
// SDRAM clock generation is left to the board
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_burst_top (
  input  logic                     clk,
  input  logic                     reset,
  input  sdram_pkg::host_req_t     req,
  input  logic                     end_burst,
  input  logic [`SDRAM_DATA_W-1:0] dq_in,
  output sdram_pkg::sdram_bus_t    bus,
  output logic [`SDRAM_DATA_W-1:0] dq_out,
  output logic                     dq_oe,
  output logic [`SDRAM_DATA_W-1:0] q,
  output logic                     init_complete,
  output logic                     available,
  output logic                     ready,
  output logic                     data_available
);

  sdram_pkg::sdram_bus_t init_bus;
  logic                  refresh_due;
  logic                  refresh_issued;

  // Power-up sequence, drives the bus until done
  sdram_init_seq u_init_seq (
    .clk           (clk),
    .reset         (reset),
    .init_bus      (init_bus),
    .init_complete (init_complete)
  );

  // Periodic refresh request
  sdram_refresh_timer u_refresh_timer (
    .clk            (clk),
    .reset          (reset),
    .init_complete  (init_complete),
    .refresh_issued (refresh_issued),
    .refresh_due    (refresh_due)
  );

  // Host jobs, refresh issue and bus mux
  sdram_access_fsm u_access_fsm (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .end_burst      (end_burst),
    .init_bus       (init_bus),
    .init_complete  (init_complete),
    .refresh_due    (refresh_due),
    .refresh_issued (refresh_issued),
    .bus            (bus),
    .dq_out         (dq_out),
    .dq_oe          (dq_oe),
    .dq_in          (dq_in),
    .q              (q),
    .available      (available),
    .ready          (ready),
    .data_available (data_available)
  );

endmodule

// ==== sdram_chip_model.sv ====
// Behavioral SDRAM for simulation only
// Unwritten words read back a fill pattern built from the whole address
// Timing parameters are not checked, only commands are decoded
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_chip_model (
  input  logic                     clk,
  input  sdram_pkg::sdram_bus_t    bus,
  input  logic [`SDRAM_DATA_W-1:0] dq_out,
  input  logic                     dq_oe,
  output logic [`SDRAM_DATA_W-1:0] dq_in
);

  localparam int CL = `SDRAM_CAS_LATENCY;

  logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_ADDR_W-1:0]];
  logic [`SDRAM_ROW_W-1:0]  open_row [4];
  logic [`SDRAM_DATA_W-1:0] pipe [CL-1];
  logic                     bursting;
  logic [1:0]               rd_ba;
  logic [`SDRAM_COL_W-1:0]  rd_col;
  logic [`SDRAM_ADDR_W-1:0] wa;
  logic [`SDRAM_DATA_W-1:0] w;

  initial begin
    bursting = 1'b0;
    dq_in    = '0;
  end

  // Fill pattern, every address bit reaches the word
  function automatic logic [`SDRAM_DATA_W-1:0] word_at(input logic [`SDRAM_ADDR_W-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return 16'(addr) ^ 16'(addr >> 9) ^ 16'h5a3c;
  endfunction

  always @(posedge clk) begin
    // Read words move through CL-1 stages, then the DQ register
    for (int i = 1; i < CL - 1; i++) begin
      pipe[i] <= pipe[i-1];
    end
    dq_in <= pipe[CL-2];
    bursting <= 1'b0;
    case (bus.cmd)
      sdram_pkg::CMD_ACTIVE: begin
        open_row[bus.ba] <= bus.a;
      end
      sdram_pkg::CMD_WRITE: begin
        wa = {bus.ba, open_row[bus.ba], bus.a[`SDRAM_COL_W-1:0]};
        w  = word_at(wa);
        // DQM high masks the byte
        if (dq_oe && !bus.dqm[0]) w[7:0] = dq_out[7:0];
        if (dq_oe && !bus.dqm[1]) w[15:8] = dq_out[15:8];
        mem[wa] = w;
      end
      sdram_pkg::CMD_READ: begin
        pipe[0]  <= word_at({bus.ba, open_row[bus.ba], bus.a[`SDRAM_COL_W-1:0]});
        rd_ba    <= bus.ba;
        rd_col   <= bus.a[`SDRAM_COL_W-1:0] + `SDRAM_COL_W'(1);
        bursting <= 1'b1;
      end
      sdram_pkg::CMD_NOP: begin
        // Full page burst keeps going until another command
        if (bursting) begin
          pipe[0]  <= word_at({rd_ba, open_row[rd_ba], rd_col});
          rd_col   <= rd_col + `SDRAM_COL_W'(1);
          bursting <= 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== sdram_init_seq.sv ====
// Power-up command sequence, timed purely by cycle count from reset release
// Mode word is fixed to full-page sequential read bursts and single-word writes
// Bus holds NOP with DQM high until init_complete rises
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_init_seq (
  input  logic                  clk,
  input  logic                  reset,
  output sdram_pkg::sdram_bus_t init_bus,
  output logic                  init_complete
);

  // Cycle after reset release at which each command shows on the bus
  localparam int CKE_AT  = `SDRAM_INIT_WAIT / 2;
  localparam int PRE_AT  = `SDRAM_INIT_WAIT;
  localparam int REF1_AT = PRE_AT + `SDRAM_T_RP;
  localparam int REF2_AT = REF1_AT + `SDRAM_T_RFC;
  localparam int LMR_AT  = REF2_AT + `SDRAM_T_RFC;
  localparam int DONE_AT = LMR_AT + `SDRAM_T_MRD;

  // Reserved, write burst mode, op mode, CAS latency, burst type, burst length
  localparam logic [`SDRAM_ROW_W-1:0] MODE_WORD =
    {3'b000, 1'b1, 2'b00, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b111};

  // A10 high selects all banks on PRECHARGE
  localparam logic [`SDRAM_ROW_W-1:0] A10_ALL = `SDRAM_ROW_W'(1 << 10);

  logic [15:0] cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt           <= '0;
      init_complete <= 1'b0;
      init_bus.cmd  <= sdram_pkg::CMD_NOP;
      init_bus.ba   <= '0;
      init_bus.a    <= '0;
      init_bus.dqm  <= '1;
      init_bus.cke  <= 1'b0;
    end else begin
      // NOP between every init command
      init_bus.cmd <= sdram_pkg::CMD_NOP;
      if (!init_complete) begin
        cnt <= cnt + 16'd1;
      end
      // Clock enable comes up halfway through the wait
      if (cnt == 16'(CKE_AT - 1)) begin
        init_bus.cke <= 1'b1;
      end
      if (cnt == 16'(PRE_AT - 1)) begin
        init_bus.cmd <= sdram_pkg::CMD_PRECHARGE;
        init_bus.a   <= A10_ALL;
      end
      // Two refreshes spaced by tRFC
      if (cnt == 16'(REF1_AT - 1) || cnt == 16'(REF2_AT - 1)) begin
        init_bus.cmd <= sdram_pkg::CMD_AUTO_REFRESH;
      end
      if (cnt == 16'(LMR_AT - 1)) begin
        init_bus.cmd <= sdram_pkg::CMD_LOAD_MODE;
        init_bus.ba  <= 2'b00;
        init_bus.a   <= MODE_WORD;
      end
      // Handover to the access FSM once tMRD has passed
      if (cnt == 16'(DONE_AT - 1)) begin
        init_complete <= 1'b1;
      end
    end
  end

  // Done is sticky until the next reset
  assert property (@(posedge clk) disable iff (reset) init_complete |=> init_complete)
    else $error("init_complete fell after rising");

endmodule

// ==== sdram_macros.svh ====
// Widths and cycle timings for the SDRAM controller and its testbench
// All timings are whole clock cycles, with no conversion from nanoseconds
// CAS latency must be 2 or 3
// INIT_WAIT is shortened for simulation and must be raised for real silicon
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Host word address and data
`define SDRAM_ADDR_W 25
`define SDRAM_DATA_W 16

// Chip geometry, 4 banks of 8192 rows by 1024 columns
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 10

// Chip timings in cycles
`define SDRAM_CAS_LATENCY 2
`define SDRAM_T_RCD 3
`define SDRAM_T_RP 3
`define SDRAM_T_RFC 6
`define SDRAM_T_WR_RP 5
`define SDRAM_T_MRD 2

// Controller timings in cycles
`define SDRAM_INIT_WAIT 200
`define SDRAM_REFRESH_PERIOD 390
`define SDRAM_PAGE_GUARD 16

`endif

// ==== sdram_pkg.sv ====
// Shared types for the SDRAM controller
// Command encoding is the raw level of nCS, nRAS, nCAS, nWE
`include "sdram_macros.svh"

package sdram_pkg;

  // Chip select, RAS, CAS, WE, all active low
  typedef enum logic [3:0] {
    CMD_NOP          = 4'b0111,
    CMD_ACTIVE       = 4'b0011,
    CMD_READ         = 4'b0101,
    CMD_WRITE        = 4'b0100,
    CMD_PRECHARGE    = 4'b0010,
    CMD_AUTO_REFRESH = 4'b0001,
    CMD_LOAD_MODE    = 4'b0000
  } sdram_cmd_e;

  // Access FSM states after init
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT,
    ST_WRITE,
    ST_READ,
    ST_BURST
  } access_state_e;

  // Host request, wr or rd high for one cycle starts a job
  typedef struct packed {
    logic [`SDRAM_ADDR_W-1:0]   addr;
    logic [`SDRAM_DATA_W-1:0]   data;
    logic [`SDRAM_DATA_W/8-1:0] byte_en;
    logic                       wr;
    logic                       rd;
  } host_req_t;

  // Everything on the chip bus except DQ
  typedef struct packed {
    sdram_cmd_e                 cmd;
    logic [1:0]                 ba;
    logic [`SDRAM_ROW_W-1:0]    a;
    logic [`SDRAM_DATA_W/8-1:0] dqm;
    logic                       cke;
  } sdram_bus_t;

endpackage

// ==== sdram_refresh_timer.sv ====
// Auto refresh interval timer
// Starts counting only once init is complete
// refresh_due stays high until the access FSM reports a refresh
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_refresh_timer (
  input  logic clk,
  input  logic reset,
  input  logic init_complete,
  input  logic refresh_issued,
  output logic refresh_due
);

  logic [15:0] cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt         <= '0;
      refresh_due <= 1'b0;
    end else if (refresh_issued) begin
      cnt         <= '0;
      refresh_due <= 1'b0;
    end else if (init_complete) begin
      // Saturate so a late refresh never wraps the count
      if (cnt != '1) begin
        cnt <= cnt + 16'd1;
      end
      // Compare is registered, hence the period minus one
      refresh_due <= cnt >= 16'(`SDRAM_REFRESH_PERIOD - 1);
    end
  end

  // The FSM only refreshes once the init sequencer has handed over
  assert property (@(posedge clk) disable iff (reset) refresh_issued |-> init_complete)
    else $error("refresh issued during init");

endmodule

// ==== tb_sdram_burst.sv ====
// Testbench for the SDRAM burst controller with a behavioral chip
// Inputs change on the falling edge, outputs are sampled on clock edges
// A watchdog bounds the run
`timescale 1ns/1ps
`include "sdram_macros.svh"

module tb_sdram_burst;

  localparam int CL          = `SDRAM_CAS_LATENCY;
  localparam int INIT_CYCLES = `SDRAM_INIT_WAIT + `SDRAM_T_RP + 2 * `SDRAM_T_RFC + `SDRAM_T_MRD;
  localparam int REF_SLACK   = 24;
  localparam int TEST_CYCLES = 4 * `SDRAM_REFRESH_PERIOD + 800;
  localparam logic [`SDRAM_ROW_W-1:0] MODE_EXP = `SDRAM_ROW_W'((1 << 9) | (CL << 4) | 7);

  logic clk = 1'b0;
  logic reset;
  logic end_burst;
  sdram_pkg::host_req_t req;
  sdram_pkg::sdram_bus_t bus;
  logic [`SDRAM_DATA_W-1:0] dq_out, dq_in, q;
  logic dq_oe, init_complete, available, ready, data_available;

  int errors = 0;
  int hs_errors = 0;
  int seed = 68600;
  int cyc, gap, splits = 0;
  logic job_open;
  logic [1:0] last_be;
  logic [`SDRAM_DATA_W-1:0] rx [$];
  logic [`SDRAM_DATA_W-1:0] shadow [logic [`SDRAM_ADDR_W-1:0]];
  sdram_pkg::sdram_bus_t init_cmds [$];

  always #10 clk = ~clk;

  sdram_burst_top dut (.*);
  sdram_chip_model chip (.clk(clk), .bus(bus), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in));

  ////////////////////
  // Expected values

  function automatic logic [15:0] expected_word(input logic [`SDRAM_ADDR_W-1:0] addr);
    if (shadow.exists(addr)) return shadow[addr];
    return 16'(addr) ^ 16'(addr >> 9) ^ 16'h5a3c;
  endfunction

  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] nw,
                                              input logic [1:0] be);
    return {be[1] ? nw[15:8] : old[15:8], be[0] ? nw[7:0] : old[7:0]};
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    assert (got === exp)
      else begin
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, msg, got, exp);
      end
  endtask

  ////////////////////
  // Monitors

  // Read words and init commands, sampled before the edge updates them
  always @(posedge clk) begin
    if (data_available) rx.push_back(q);
    if (!reset && !init_complete && bus.cmd != sdram_pkg::CMD_NOP) init_cmds.push_back(bus);
    cyc <= reset ? 0 : (init_complete ? cyc : cyc + 1);
  end

  // Longest stretch without AUTO_REFRESH after init
  always @(posedge clk) begin
    if (reset || !init_complete || bus.cmd == sdram_pkg::CMD_AUTO_REFRESH) begin
      gap <= 0;
    end else begin
      gap <= gap + 1;
    end
    if (init_complete) begin
      assert (gap <= `SDRAM_REFRESH_PERIOD + REF_SLACK)
        else begin
          errors++;
          $display("refresh gap of %0d cycles is too long at %0t", gap, $time);
        end
    end
    if (init_complete && bus.cmd == sdram_pkg::CMD_WRITE) begin
      check_eq(bus.dqm, 2'(~last_be), "dqm");
    end
  end

  // Open from the request edge until the ready pulse is seen
  always @(posedge clk) begin
    if (reset || ready) begin
      job_open <= 1'b0;
    end else if (req.wr || req.rd) begin
      job_open <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else begin
      errors++;
      hs_errors++;
      $display("ready stayed high for two cycles at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (reset) (req.wr || req.rd) |=> !available)
    else begin
      errors++;
      hs_errors++;
      $display("available stayed high after a request at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (reset) job_open |-> !available)
    else begin
      errors++;
      hs_errors++;
      $display("available high while a job is open at %0t", $time);
    end

  ////////////////////
  // Host tasks

  task automatic issue_req(input logic [`SDRAM_ADDR_W-1:0] addr, input logic [15:0] data,
                           input logic [1:0] be, input logic wr);
    while (!available) @(negedge clk);
    req.addr    = addr;
    req.data    = data;
    req.byte_en = be;
    req.wr      = wr;
    req.rd      = !wr;
    @(negedge clk);
    req.wr = 1'b0;
    req.rd = 1'b0;
  endtask

  task automatic write_word(input logic [`SDRAM_ADDR_W-1:0] addr);
    logic [15:0] d;
    logic [1:0] be;
    int rdy;
    d = 16'($random(seed));
    be = 2'($random(seed));
    last_be = be;
    rdy = 0;
    issue_req(addr, d, be, 1'b1);
    while (!available) begin
      if (ready) rdy++;
      @(negedge clk);
    end
    check_eq(rdy, 1, "ready pulses per write");
    shadow[addr] = merge_bytes(expected_word(addr), d, be);
  endtask

  // Reads n words, re-requesting where a refresh cut the burst
  task automatic read_seq(input logic [`SDRAM_ADDR_W-1:0] start, input int n);
    bit cut;
    int base, rdy;
    rx.delete();
    cut = 1'b1;
    while (cut && rx.size() < n) begin
      issue_req(start + `SDRAM_ADDR_W'(rx.size()), '0, '0, 1'b0);
      cut = 1'b0;
      while (rx.size() < n && !cut) begin
        @(negedge clk);
        if (ready) begin
          cut = 1'b1;
          splits++;
        end
      end
    end
    if (!cut) begin
      end_burst = 1'b1;
      @(negedge clk);
      end_burst = 1'b0;
      // Words from here on arrived after the end_burst cycle
      base = rx.size();
      check_eq(bus.cmd, sdram_pkg::CMD_PRECHARGE, "command after end_burst");
      rdy = 0;
      while (!available) begin
        if (ready) rdy++;
        @(negedge clk);
      end
      check_eq(rdy, 1, "ready pulses per burst");
      assert (rx.size() - base <= CL)
        else begin
          errors++;
          $display("too many words after end_burst at %0t", $time);
        end
    end
    foreach (rx[k]) check_eq(rx[k], expected_word(start + `SDRAM_ADDR_W'(k)), "burst word");
  endtask

  task automatic report(input string name, input int fails);
    $display("%s: %s", name, fails == 0 ? "pass" : "fail");
  endtask

  ////////////////////
  // Stimulus

  initial begin
    int e;
    reset = 1'b1;
    req = '0;
    end_burst = 1'b0;
    last_be = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    e = errors;
    while (!init_complete) @(negedge clk);
    check_eq(cyc, INIT_CYCLES, "init length");
    check_eq(init_cmds.size(), 4, "init command count");
    if (init_cmds.size() == 4) begin
      check_eq(init_cmds[0].cmd, sdram_pkg::CMD_PRECHARGE, "init cmd 0");
      check_eq(init_cmds[0].a[10], 1'b1, "precharge all");
      check_eq(init_cmds[1].cmd, sdram_pkg::CMD_AUTO_REFRESH, "init cmd 1");
      check_eq(init_cmds[2].cmd, sdram_pkg::CMD_AUTO_REFRESH, "init cmd 2");
      check_eq(init_cmds[3].cmd, sdram_pkg::CMD_LOAD_MODE, "init cmd 3");
      check_eq(init_cmds[3].a, MODE_EXP, "mode word");
      foreach (init_cmds[i]) check_eq(init_cmds[i].cke, 1'b1, "cke before command");
    end
    report("init", errors - e);

    e = errors;
    for (int i = 0; i < 4; i++) write_word(25'h0123400 + 25'(i));
    read_seq(25'h0123400, 4);
    report("write_readback", errors - e);

    e = errors;
    read_seq(25'h1a500c0, 40);
    report("seq_burst", errors - e);

    e = errors;
    read_seq(25'h0badd17, 1);
    report("end_burst", errors - e);

    e = errors;
    repeat (2 * `SDRAM_REFRESH_PERIOD + 50) @(negedge clk);
    read_seq(25'h0800000, 700);
    assert (splits > 0)
      else begin
        errors++;
        $display("long burst was never cut by a refresh");
      end
    report("refresh", errors - e);
    report("handshake", hs_errors);

    $display("6 tests run, %0d failed checks", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog at twice the expected run length
  initial begin
    #((INIT_CYCLES + TEST_CYCLES) * 2 * 20);
    $display("timeout: the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule
